// File: vlog.f
+incdir+.
safetyPkg.sv
hornPkg.sv
inputConditioner.sv
lampSequencer.sv
lampPwm.sv
hornRamp.sv
SafetyControls.sv
SafetyControls_properties.sv
tb_SafetyControls.sv

// File: run.sh
#!/bin/sh
# Build and run tb_SafetyControls with Verilator, fail when the log holds the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_SafetyControls \
    -f vlog.f -o simv || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: failing"; exit 1; } \
    || echo "Result: passing"

// File: tb_SafetyControls.sv
// Testbench for SafetyControls with glitch, latency, blinker, brake lamp, horn and reset checks
`timescale 1ns/1ps
`include "safety_cfg.svh"

module tb_SafetyControls;

    // Largest DAC swing from mid scale, half of full amplitude
    localparam int MaxDev = 255 / 2;

    logic       CLOCK_50;
    logic       arstN;
    logic       leftBlinker;
    logic       rightBlinker;
    logic       headLight;
    logic       horn;
    logic       brakes;
    logic       leftBlinkerOut;
    logic       rightBlinkerOut;
    logic       headLightOut;
    logic       brakeLightOut;
    logic [7:0] DACout;

    int errCount = 0;
    int timeoutCount = 0;
    int len;
    int n;
    int prevDev;
    int highCnt;

    SafetyControls u_dut (.*);

    always #10 CLOCK_50 = ~CLOCK_50;

    // Step the given number of rising edges, then 1 ns on where inputs change
    task automatic tick(input int cycles);
        repeat (cycles) @(posedge CLOCK_50);
        #1;
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            errCount++;
            $display("Fail at %0t ns: %s", $time, msg);
        end
    endtask

    // Index order left, right, head, horn, brake; brake pin is active low
    task automatic setInput(input int idx, input logic v);
        case (idx)
            0: leftBlinker = v;
            1: rightBlinker = v;
            2: headLight = v;
            3: horn = v;
            default: brakes = ~v;
        endcase
    endtask

    function automatic int absDev(input logic [7:0] v);
        return (int'(v) >= `DAC_MID) ? int'(v) - `DAC_MID : `DAC_MID - int'(v);
    endfunction

    // Flash runs of BLINK_HALF_CYCLES, starting lit, on the selected lamps
    task automatic checkFlash(input logic wantLeft, input logic wantRight);
        logic lit;
        for (int j = 0; j < 4 * `BLINK_HALF_CYCLES; j++) begin
            lit = ((j / `BLINK_HALF_CYCLES) % 2) == 0;
            check(leftBlinkerOut == (wantLeft && lit), "left blinker level wrong");
            check(rightBlinkerOut == (wantRight && lit), "right blinker level wrong");
            tick(1);
        end
    endtask

    initial begin
        void'($urandom(32'h3ffd));
        CLOCK_50 = 1'b0;
        arstN = 1'b0;
        leftBlinker = 1'b0;
        rightBlinker = 1'b0;
        headLight = 1'b0;
        horn = 1'b0;
        brakes = 1'b1;
        tick(4);
        arstN = 1'b1;
        check({leftBlinkerOut, rightBlinkerOut, headLightOut, brakeLightOut} == 4'b0,
              "lamp output high after reset");
        check(DACout == 8'(`DAC_MID), "DAC not at mid scale after reset");

        // Short glitch on every input, nothing may move
        for (int i = 0; i < 5; i++) begin
            tick($urandom_range(10, 2));
            len = $urandom_range(3, 1);
            setInput(i, 1'b1);
            tick(len);
            setInput(i, 1'b0);
            repeat (12) begin
                tick(1);
                check({leftBlinkerOut, rightBlinkerOut, headLightOut, brakeLightOut} == 4'b0
                      && DACout == 8'(`DAC_MID), "glitch reached an output");
            end
        end

        // Stable headlight change, expect exactly 8 cycles
        headLight = 1'b1;
        n = 0;
        while (!headLightOut && n < 40) begin
            tick(1);
            n++;
        end
        if (!headLightOut) begin
            timeoutCount++;
            $display("Timeout: headlight output never turned on");
        end
        check(n == 8, "headlight latency not 8 cycles");

        // Tail lamp duty over three PWM windows
        for (int w = 0; w < 3; w++) begin
            highCnt = 0;
            repeat (`PWM_PERIOD) begin
                if (brakeLightOut)
                    highCnt++;
                tick(1);
            end
            check(highCnt == `TAIL_DUTY, "tail lamp duty wrong");
        end

        brakes = 1'b0;
        tick(8);
        repeat (24) begin
            check(brakeLightOut, "brake lamp not full while braking");
            tick(1);
        end
        brakes = 1'b1;
        headLight = 1'b0;
        tick(8);
        repeat (16) begin
            check(!brakeLightOut && !headLightOut, "lamp lit with headlight and brake off");
            tick(1);
        end

        leftBlinker = 1'b1;
        tick(8);
        checkFlash(1'b1, 1'b0);
        leftBlinker = 1'b0;
        rightBlinker = 1'b1;
        tick(8);
        checkFlash(1'b0, 1'b1);
        leftBlinker = 1'b1;
        tick(8);
        checkFlash(1'b1, 1'b1);
        leftBlinker = 1'b0;
        rightBlinker = 1'b0;
        tick(8);
        checkFlash(1'b0, 1'b0);

        // Horn ramp up, deviation must never shrink
        horn = 1'b1;
        prevDev = 0;
        n = 0;
        while (absDev(DACout) < MaxDev && n < 300) begin
            tick(1);
            n++;
            check(absDev(DACout) >= prevDev, "horn deviation dropped while held");
            prevDev = absDev(DACout);
        end
        if (absDev(DACout) < MaxDev) begin
            timeoutCount++;
            $display("Timeout: horn never reached full amplitude");
        end
        repeat ($urandom_range(40, 8)) begin
            tick(1);
            check(absDev(DACout) == MaxDev, "horn not at full amplitude while held");
        end

        // Release, deviation must never grow and must end at mid scale
        horn = 1'b0;
        n = 0;
        while (DACout != 8'(`DAC_MID) && n < 300) begin
            tick(1);
            n++;
            check(absDev(DACout) <= prevDev, "horn deviation grew after release");
            prevDev = absDev(DACout);
        end
        if (DACout != 8'(`DAC_MID)) begin
            timeoutCount++;
            $display("Timeout: DAC never returned to mid scale");
        end
        repeat (16) begin
            tick(1);
            check(DACout == 8'(`DAC_MID), "DAC left mid scale with horn idle");
        end

        $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 errCount, timeoutCount, u_dut.uProps.failCount);
        if (errCount == 0 && timeoutCount == 0 && u_dut.uProps.failCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: SafetyControls_properties.sv
// Concurrent assertions on headlight latency, blinkers, brake lamp and DAC idle level
`timescale 1ns/1ps
`include "safety_cfg.svh"

module safetyProperties (
    input logic               CLOCK_50,
    input logic               arstN,
    input logic               headLight,
    input safetyPkg::buttonsT cleanButtons,
    input logic               leftBlinkerOut,
    input logic               rightBlinkerOut,
    input logic               brakeLightOut,
    input logic               headLightOut,
    input logic [7:0]         DACout
);

    // Number of assertion failures so far
    int failCount = 0;

    // Output edge needs four equal raw samples 5 to 8 cycles back
    aHeadRise: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $rose(headLightOut) |-> $past(headLight, 8) && $past(headLight, 7) &&
                                $past(headLight, 6) && $past(headLight, 5))
        else begin
            failCount++;
            $error("headlight rose without stable input");
        end

    aHeadFall: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $fell(headLightOut) |-> !$past(headLight, 8) && !$past(headLight, 7) &&
                                !$past(headLight, 6) && !$past(headLight, 5))
        else begin
            failCount++;
            $error("headlight fell without stable input");
        end

    // Clean buttons reach the pins two registers later
    aHazard: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $past(cleanButtons.leftBlink && cleanButtons.rightBlink, 2) |->
            leftBlinkerOut == rightBlinkerOut)
        else begin
            failCount++;
            $error("hazard lamps out of phase");
        end

    aLeftIdle: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $past(!cleanButtons.leftBlink, 2) |-> !leftBlinkerOut)
        else begin
            failCount++;
            $error("left blinker lit without request");
        end

    aRightIdle: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $past(!cleanButtons.rightBlink, 2) |-> !rightBlinkerOut)
        else begin
            failCount++;
            $error("right blinker lit without request");
        end

    aBrakeFull: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $past(cleanButtons.brake, 2) |-> brakeLightOut)
        else begin
            failCount++;
            $error("brake lamp not full while braking");
        end

    aBrakeOff: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        $past(!cleanButtons.brake && !cleanButtons.headLight, 2) |-> !brakeLightOut)
        else begin
            failCount++;
            $error("brake lamp lit with nothing on");
        end

    // Zero amplitude with horn released stays at mid scale
    aDacIdle: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        (DACout == 8'(`DAC_MID) && $past(!cleanButtons.horn)) |=> DACout == 8'(`DAC_MID))
        else begin
            failCount++;
            $error("DAC left mid scale with horn idle");
        end

endmodule

bind SafetyControls safetyProperties uProps (
    .CLOCK_50       (CLOCK_50),
    .arstN          (arstN),
    .headLight      (headLight),
    .cleanButtons   (cleanButtons),
    .leftBlinkerOut (leftBlinkerOut),
    .rightBlinkerOut(rightBlinkerOut),
    .brakeLightOut  (brakeLightOut),
    .headLightOut   (headLightOut),
    .DACout         (DACout)
);

// File: SafetyControls.sv
// Safety control top level, input conditioning to lamp and horn stages
`timescale 1ns/1ps

module SafetyControls (
    input  logic       CLOCK_50,
    input  logic       arstN,
    input  logic       leftBlinker,
    input  logic       rightBlinker,
    input  logic       headLight,
    input  logic       horn,
    // Active low
    input  logic       brakes,
    output logic       leftBlinkerOut,
    output logic       rightBlinkerOut,
    output logic       headLightOut,
    output logic       brakeLightOut,
    output logic [7:0] DACout
);

    safetyPkg::buttonsT cleanButtons;
    safetyPkg::lampCmdT lampCmd;
    hornPkg::dacSampleT dacSample;

    // Sync and debounce, brake flipped to active high here
    inputConditioner uInputConditioner (
        .CLOCK_50    (CLOCK_50),
        .arstN       (arstN),
        .leftBlinker (leftBlinker),
        .rightBlinker(rightBlinker),
        .headLight   (headLight),
        .horn        (horn),
        .brakes      (brakes),
        .cleanButtons(cleanButtons)
    );

    // Blinker FSM and brake level choice
    lampSequencer uLampSequencer (
        .CLOCK_50    (CLOCK_50),
        .arstN       (arstN),
        .cleanButtons(cleanButtons),
        .lampCmd     (lampCmd)
    );

    // Lamp pins
    lampPwm uLampPwm (
        .CLOCK_50       (CLOCK_50),
        .arstN          (arstN),
        .lampCmd        (lampCmd),
        .leftBlinkerOut (leftBlinkerOut),
        .rightBlinkerOut(rightBlinkerOut),
        .headLightOut   (headLightOut),
        .brakeLightOut  (brakeLightOut)
    );

    // Horn runs beside the lamp path
    hornRamp uHornRamp (
        .CLOCK_50(CLOCK_50),
        .arstN   (arstN),
        .hornOn  (cleanButtons.horn),
        .sample  (dacSample)
    );

    assign DACout = dacSample.value;

endmodule

// File: hornRamp.sv
// Horn amplitude ramp FSM and square tone DAC sample generation
`timescale 1ns/1ps
`include "safety_cfg.svh"

module hornRamp (
    input  logic              CLOCK_50,
    input  logic              arstN,
    input  logic              hornOn,
    output hornPkg::dacSampleT sample
);

    localparam int ToneW = $clog2(2 * `TONE_HALF_CYCLES + 1);

    hornPkg::rampStateT rampState;
    logic [ToneW-1:0]   toneCnt;
    logic [7:0]         amp;
    logic [8:0]         ampSum;
    logic               periodEnd;
    logic               toneHigh;
    logic               atFloor;

    // Tone divider, never stops
    assign periodEnd = (toneCnt == ToneW'(2 * `TONE_HALF_CYCLES - 1));
    assign toneHigh  = (toneCnt < ToneW'(`TONE_HALF_CYCLES));

    // Up step in 9 bits to catch overflow, down step clamps at zero
    assign ampSum  = {1'b0, amp} + 9'(`RAMP_STEP);
    assign atFloor = (amp <= 8'(`RAMP_STEP));

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            toneCnt   <= '0;
            amp       <= '0;
            rampState <= hornPkg::rampIdle;
        end else begin
            toneCnt <= periodEnd ? '0 : toneCnt + 1'b1;
            // Amplitude only moves at tone period boundaries
            if (periodEnd) begin
                if (hornOn && rampState != hornPkg::rampHold) begin
                    amp       <= ampSum[8] ? 8'hff : ampSum[7:0];
                    rampState <= ampSum[8] ? hornPkg::rampHold : hornPkg::rampUp;
                end else if (!hornOn && rampState != hornPkg::rampIdle) begin
                    amp       <= atFloor ? 8'h00 : amp - 8'(`RAMP_STEP);
                    rampState <= atFloor ? hornPkg::rampIdle : hornPkg::rampDown;
                end
            end
        end
    end

    // Square wave around mid scale, half amplitude each side
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN)
            sample.value <= 8'(`DAC_MID);
        else if (toneHigh)
            sample.value <= 8'(`DAC_MID) + {1'b0, amp[7:1]};
        else
            sample.value <= 8'(`DAC_MID) - {1'b0, amp[7:1]};
    end

endmodule

// File: lampPwm.sv
// Brake and tail lamp PWM plus registered lamp output drivers
`timescale 1ns/1ps
`include "safety_cfg.svh"

module lampPwm (
    input  logic               CLOCK_50,
    input  logic               arstN,
    input  safetyPkg::lampCmdT lampCmd,
    output logic               leftBlinkerOut,
    output logic               rightBlinkerOut,
    output logic               headLightOut,
    output logic               brakeLightOut
);

    localparam int PwmW = $clog2(`PWM_PERIOD + 1);

    logic [PwmW-1:0] pwmCnt;
    logic            tailHigh;

    // Free running PWM period counter
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN)
            pwmCnt <= '0;
        else if (pwmCnt == PwmW'(`PWM_PERIOD - 1))
            pwmCnt <= '0;
        else
            pwmCnt <= pwmCnt + 1'b1;
    end

    // Tail lamp lit for the first TAIL_DUTY cycles of each period
    assign tailHigh = (pwmCnt < PwmW'(`TAIL_DUTY));

    // All pins registered so every lamp has the same latency
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            leftBlinkerOut  <= 1'b0;
            rightBlinkerOut <= 1'b0;
            headLightOut    <= 1'b0;
            brakeLightOut   <= 1'b0;
        end else begin
            leftBlinkerOut  <= lampCmd.leftOn;
            rightBlinkerOut <= lampCmd.rightOn;
            headLightOut    <= lampCmd.headOn;
            unique case (lampCmd.brakeLevel)
                safetyPkg::levelFull: brakeLightOut <= 1'b1;
                safetyPkg::levelTail: brakeLightOut <= tailHigh;
                default:              brakeLightOut <= 1'b0;
            endcase
        end
    end

endmodule

// File: lampSequencer.sv
// Blinker and hazard FSM with flash phase, headlight and brake level select
`timescale 1ns/1ps
`include "safety_cfg.svh"

module lampSequencer (
    input  logic               CLOCK_50,
    input  logic               arstN,
    input  safetyPkg::buttonsT cleanButtons,
    output safetyPkg::lampCmdT lampCmd
);

    localparam int PhW = $clog2(`BLINK_HALF_CYCLES + 1);

    safetyPkg::blinkStateT blinkState;
    safetyPkg::blinkStateT nextState;
    logic [PhW-1:0]        phaseCnt;
    logic                  flashOn;
    logic                  nextFlash;
    logic                  stateChange;
    logic                  halfDone;

    // Both buttons held means hazard
    always_comb begin
        unique case ({cleanButtons.leftBlink, cleanButtons.rightBlink})
            2'b11:   nextState = safetyPkg::blinkHazard;
            2'b10:   nextState = safetyPkg::blinkLeft;
            2'b01:   nextState = safetyPkg::blinkRight;
            default: nextState = safetyPkg::blinkIdle;
        endcase
    end

    assign stateChange = (nextState != blinkState);
    assign halfDone    = (phaseCnt == PhW'(`BLINK_HALF_CYCLES - 1));

    // New state always starts with the lamp lit
    assign nextFlash = stateChange ? 1'b1 : (halfDone ? ~flashOn : flashOn);

    // Flash phase, restarted on every state change
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            blinkState <= safetyPkg::blinkIdle;
            phaseCnt   <= '0;
            flashOn    <= 1'b0;
        end else begin
            blinkState <= nextState;
            flashOn    <= nextFlash;
            if (stateChange || halfDone)
                phaseCnt <= '0;
            else
                phaseCnt <= phaseCnt + 1'b1;
        end
    end

    // Registered command, one cycle behind cleanButtons
    // Hazard drives both lamps from the same flash bit
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            lampCmd <= '0;
        end else begin
            lampCmd.leftOn  <= nextFlash && (nextState == safetyPkg::blinkLeft ||
                                             nextState == safetyPkg::blinkHazard);
            lampCmd.rightOn <= nextFlash && (nextState == safetyPkg::blinkRight ||
                                             nextState == safetyPkg::blinkHazard);
            lampCmd.headOn  <= cleanButtons.headLight;
            // Braking wins over tail light
            if (cleanButtons.brake)
                lampCmd.brakeLevel <= safetyPkg::levelFull;
            else if (cleanButtons.headLight)
                lampCmd.brakeLevel <= safetyPkg::levelTail;
            else
                lampCmd.brakeLevel <= safetyPkg::levelOff;
        end
    end

endmodule

// File: inputConditioner.sv
// Input synchronizers and per-bit debounce counters
`timescale 1ns/1ps
`include "safety_cfg.svh"

module inputConditioner (
    input  logic               CLOCK_50,
    input  logic               arstN,
    input  logic               leftBlinker,
    input  logic               rightBlinker,
    input  logic               headLight,
    input  logic               horn,
    input  logic               brakes,
    output safetyPkg::buttonsT cleanButtons
);

    localparam int DbW = $clog2(`DEBOUNCE_CYCLES + 1);

    // Raw levels in buttonsT bit order, brake flipped to active high
    logic [4:0] rawVec;
    logic [4:0] syncA;
    logic [4:0] syncB;
    logic [4:0] cleanVec;

    assign rawVec = {leftBlinker, rightBlinker, headLight, horn, ~brakes};

    // Two flop synchronizer on every input
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= rawVec;
            syncB <= syncA;
        end
    end

    genvar i;
    generate
        for (i = 0; i < 5; i++) begin : gDebounce
            logic [DbW-1:0] stableCnt;
            logic           cleanBit;

            // Count cycles the synced bit differs from the clean bit
            // Any return to the clean value restarts the count
            always_ff @(posedge CLOCK_50 or negedge arstN) begin
                if (!arstN) begin
                    stableCnt <= '0;
                    cleanBit  <= 1'b0;
                end else if (syncB[i] == cleanBit) begin
                    stableCnt <= '0;
                end else if (stableCnt == DbW'(`DEBOUNCE_CYCLES - 1)) begin
                    // Held long enough, accept new level
                    cleanBit  <= syncB[i];
                    stableCnt <= '0;
                end else begin
                    stableCnt <= stableCnt + 1'b1;
                end
            end

            assign cleanVec[i] = cleanBit;
        end
    endgenerate

    assign cleanButtons = safetyPkg::buttonsT'(cleanVec);

endmodule

// File: hornPkg.sv
// Horn ramp FSM states and DAC sample type
package hornPkg;

    // Amplitude ramp FSM
    typedef enum logic [1:0] {
        rampIdle = 2'd0,
        rampUp   = 2'd1,
        rampHold = 2'd2,
        rampDown = 2'd3
    } rampStateT;

    // One DAC sample, unsigned, idle at mid scale
    typedef struct packed {
        logic [7:0] value;
    } dacSampleT;

endpackage

// File: safetyPkg.sv
// Button and lamp command structs, blinker and brake lamp enums
package safetyPkg;

    // Conditioned driver inputs, brake already active high
    typedef struct packed {
        logic leftBlink;
        logic rightBlink;
        logic headLight;
        logic horn;
        logic brake;
    } buttonsT;

    // Blinker FSM states
    typedef enum logic [1:0] {
        blinkIdle   = 2'd0,
        blinkLeft   = 2'd1,
        blinkRight  = 2'd2,
        blinkHazard = 2'd3
    } blinkStateT;

    // Brake lamp brightness request
    typedef enum logic [1:0] {
        levelOff  = 2'd0,
        levelTail = 2'd1,
        levelFull = 2'd2
    } brakeLevelT;

    // Lamp command from sequencer to PWM stage, five bits
    typedef struct packed {
        logic       leftOn;
        logic       rightOn;
        logic       headOn;
        brakeLevelT brakeLevel;
    } lampCmdT;

endpackage

// File: safety_cfg.svh
// Timing constants for debounce, blinker flash, lamp PWM and horn tone
// Defaults are kept small for short simulation runs
`ifndef SAFETY_CFG_SVH
`define SAFETY_CFG_SVH

// Cycles an input must stay stable before the clean value follows
`define DEBOUNCE_CYCLES 4

// On time and off time of one blinker flash
`define BLINK_HALF_CYCLES 16

// Lamp PWM period length
`define PWM_PERIOD 8

// High cycles per PWM period for the dimmed tail lamp
`define TAIL_DUTY 2

// Half period of the horn square tone
`define TONE_HALF_CYCLES 4

// Amplitude change per tone period
`define RAMP_STEP 32

// DAC idle level, mid scale
`define DAC_MID 128

`endif
